/* all.f */
design/gb_bus_pkg.sv
design/gb_memory_map.sv
design/gb_work_ram.sv
design/gb_timer.sv
design/gb_interrupt_flags.sv
design/gb_read_mux.sv
design/gb_bus_top.sv
testbench/gb_bus_tb.sv

/* Bender.yml */
package:
  name: gb_bus

sources:
  - design/gb_bus_pkg.sv
  - design/gb_memory_map.sv
  - design/gb_work_ram.sv
  - design/gb_timer.sv
  - design/gb_interrupt_flags.sv
  - design/gb_read_mux.sv
  - design/gb_bus_top.sv
  - target: simulation
    files:
      - testbench/gb_bus_tb.sv

/* testbench/gb_bus_tb.sv */
/*
 * Testbench for gb_bus_top with the default 8 KiB work RAM.
 * A reference model tracks work RAM, boot register, IF, IE and the timer.
 * Boot ROM answers with the inverted low address byte, cartridge with low byte plus one.
 */

`timescale 1ns/1ps

module gb_bus_tb;

   // the stimulus needs well under a thousand cycles
   localparam int max_cycles = 20000;

   logic              clock;
   logic              reset;
   gb_bus_pkg::addr_t cpu_addr;
   gb_bus_pkg::byte_t cpu_wdata;
   logic              cpu_we;
   logic              cpu_re;
   gb_bus_pkg::byte_t boot_rom_data;
   gb_bus_pkg::byte_t cart_data;
   logic              vblank_req;
   logic              lcdc_req;
   logic              joypad_req;
   gb_bus_pkg::byte_t cpu_rdata;
   gb_bus_pkg::irq_t  if_flags;
   gb_bus_pkg::irq_t  ie_flags;
   gb_bus_pkg::addr_t boot_rom_addr;
   gb_bus_pkg::addr_t cart_addr;

   // reference model state
   gb_bus_pkg::byte_t model_ram [8192];
   gb_bus_pkg::byte_t model_boot;
   gb_bus_pkg::irq_t  model_if;
   gb_bus_pkg::irq_t  model_ie;
   logic [15:0]       model_counter;
   gb_bus_pkg::byte_t model_tima;
   gb_bus_pkg::byte_t model_tma;
   logic [2:0]        model_tac;
   logic              model_irq;
   logic [15:0]       tick_mask;
   logic              model_tick;
   gb_bus_pkg::irq_t  requests;
   logic              rdata_valid;
   gb_bus_pkg::byte_t rdata_expect;

   int cycle_count = 0;
   int read_errors = 0;
   int flag_errors = 0;
   int other_errors = 0;

   gb_bus_top dut_i (
      .clock(clock), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .cpu_we(cpu_we), .cpu_re(cpu_re), .boot_rom_data(boot_rom_data),
      .cart_data(cart_data), .vblank_req(vblank_req), .lcdc_req(lcdc_req),
      .joypad_req(joypad_req), .cpu_rdata(cpu_rdata), .if_flags(if_flags),
      .ie_flags(ie_flags), .boot_rom_addr(boot_rom_addr), .cart_addr(cart_addr)
   );

   // external memories answer combinationally
   assign boot_rom_data = ~boot_rom_addr[7:0];
   assign cart_data     = cart_addr[7:0] + 8'd1;

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("timeout: run stopped after %0d cycles", cycle_count);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // byte the bus should return for a read of a, from model state
   function automatic gb_bus_pkg::byte_t expected_read(gb_bus_pkg::addr_t a);
      gb_bus_pkg::byte_t result;
      result = 8'h00;
      if (a <= 16'h00ff && !model_boot[0]) begin
         result = ~a[7:0];
      end else if (a <= 16'h7fff) begin
         result = a[7:0] + 8'd1;
      end else if (a >= 16'hc000 && a <= 16'hfdff) begin
         result = model_ram[a[12:0]];
      end else if (a == gb_bus_pkg::addr_div) begin
         result = model_counter[15:8];
      end else if (a == gb_bus_pkg::addr_tima) begin
         result = model_tima;
      end else if (a == gb_bus_pkg::addr_tma) begin
         result = model_tma;
      end else if (a == gb_bus_pkg::addr_tac) begin
         result = {5'b00000, model_tac};
      end else if (a == gb_bus_pkg::addr_if) begin
         result = {3'b000, model_if};
      end else if (a == gb_bus_pkg::addr_ie) begin
         result = {3'b000, model_ie};
      end else if (a == gb_bus_pkg::addr_boot) begin
         result = model_boot;
      end
      return result;
   endfunction

   always_comb begin
      case (model_tac[1:0])
         2'd0:    tick_mask = 16'h03ff;
         2'd1:    tick_mask = 16'h000f;
         2'd2:    tick_mask = 16'h003f;
         default: tick_mask = 16'h00ff;
      endcase
   end

   assign model_tick = model_tac[2] && ((model_counter & tick_mask) == tick_mask);
   assign requests   = {joypad_req, 1'b0, model_irq, lcdc_req, vblank_req};

   always @(posedge clock or posedge reset) begin
      if (reset) begin
         model_boot    <= '0;
         model_if      <= '0;
         model_ie      <= '0;
         model_counter <= '0;
         model_tima    <= '0;
         model_tma     <= '0;
         model_tac     <= '0;
         model_irq     <= 1'b0;
         rdata_valid   <= 1'b0;
         rdata_expect  <= '0;
      end else begin
         rdata_valid <= cpu_re;
         if (cpu_re) begin
            rdata_expect <= expected_read(cpu_addr);
         end
         model_counter <= (cpu_we && cpu_addr == gb_bus_pkg::addr_div) ? 16'd0
                                                                       : model_counter + 16'd1;
         model_irq <= 1'b0;
         if (cpu_we && cpu_addr == gb_bus_pkg::addr_tima) begin
            model_tima <= cpu_wdata;
         end else if (model_tick) begin
            model_tima <= (model_tima == 8'hff) ? model_tma : model_tima + 8'd1;
            model_irq  <= (model_tima == 8'hff);
         end
         if (cpu_we && cpu_addr == gb_bus_pkg::addr_tma) model_tma <= cpu_wdata;
         if (cpu_we && cpu_addr == gb_bus_pkg::addr_tac) model_tac <= cpu_wdata[2:0];
         if (cpu_we && cpu_addr == gb_bus_pkg::addr_ie) model_ie <= cpu_wdata[4:0];
         if (cpu_we && cpu_addr == gb_bus_pkg::addr_boot) model_boot <= cpu_wdata;
         if (cpu_we && cpu_addr == gb_bus_pkg::addr_if) begin
            model_if <= cpu_wdata[4:0] | requests;
         end else begin
            model_if <= model_if | requests;
         end
         // echo and work RAM share the low 13 address bits
         if (cpu_we && cpu_addr >= 16'hc000 && cpu_addr <= 16'hfdff) begin
            model_ram[cpu_addr[12:0]] <= cpu_wdata;
         end
      end
   end

   read_data_matches: assert property (@(posedge clock) disable iff (reset)
      rdata_valid |-> cpu_rdata == rdata_expect)
      else begin
         read_errors++;
         $display("[FAIL] t=%0t cpu_rdata expected %02h actual %02h",
                  $time, $sampled(rdata_expect), $sampled(cpu_rdata));
      end

   if_flags_match: assert property (@(posedge clock) disable iff (reset)
      if_flags == model_if)
      else begin
         flag_errors++;
         $display("[FAIL] t=%0t if_flags expected %02h actual %02h",
                  $time, $sampled(model_if), $sampled(if_flags));
      end

   ie_flags_match: assert property (@(posedge clock) disable iff (reset)
      ie_flags == model_ie)
      else begin
         flag_errors++;
         $display("[FAIL] t=%0t ie_flags expected %02h actual %02h",
                  $time, $sampled(model_ie), $sampled(ie_flags));
      end

   // the external memories see the full CPU address
   boot_rom_addr_match: assert property (@(posedge clock) disable iff (reset)
      boot_rom_addr == cpu_addr)
      else begin
         other_errors++;
         $display("[FAIL] t=%0t boot_rom_addr expected %04h actual %04h",
                  $time, $sampled(cpu_addr), $sampled(boot_rom_addr));
      end

   cart_addr_match: assert property (@(posedge clock) disable iff (reset)
      cart_addr == cpu_addr)
      else begin
         other_errors++;
         $display("[FAIL] t=%0t cart_addr expected %04h actual %04h",
                  $time, $sampled(cpu_addr), $sampled(cart_addr));
      end

   // each access task starts and ends on a falling edge
   task automatic write_byte(input gb_bus_pkg::addr_t a, input gb_bus_pkg::byte_t d);
      cpu_addr  = a;
      cpu_wdata = d;
      cpu_we    = 1'b1;
      @(negedge clock);
      cpu_we = 1'b0;
   endtask

   task automatic read_byte(input gb_bus_pkg::addr_t a);
      cpu_addr = a;
      cpu_re   = 1'b1;
      @(negedge clock);
      cpu_re = 1'b0;
   endtask

   task automatic pulse_requests(input logic v, input logic l, input logic j);
      vblank_req = v;
      lcdc_req   = l;
      joypad_req = j;
      @(negedge clock);
      vblank_req = 1'b0;
      lcdc_req   = 1'b0;
      joypad_req = 1'b0;
   endtask

   initial begin
      gb_bus_pkg::addr_t written[$];
      gb_bus_pkg::addr_t a;
      int                waited;
      void'($urandom(32'hf0453db6));
      reset      = 1'b1;
      cpu_addr   = '0;
      cpu_wdata  = '0;
      cpu_we     = 1'b0;
      cpu_re     = 1'b0;
      vblank_req = 1'b0;
      lcdc_req   = 1'b0;
      joypad_req = 1'b0;
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      @(negedge clock);

      // boot overlay still active
      read_byte(16'h0050);
      read_byte(16'h0150);
      read_byte(gb_bus_pkg::addr_boot);

      // random work RAM traffic
      for (int i = 0; i < 32; i++) begin
         a = 16'hc000 + 16'($urandom_range(16'h1fff));
         written.push_back(a);
         write_byte(a, 8'($urandom));
      end
      foreach (written[k]) read_byte(written[k]);
      write_byte(16'hc123, 8'h5a);
      read_byte(16'he123);
      write_byte(16'hfd00, 8'h3c);
      read_byte(16'hdd00);

      // RAM cells that share low address bits with the unmapped addresses
      write_byte(16'hc000, 8'h11);
      write_byte(16'hde00, 8'h22);
      write_byte(16'hdf80, 8'h33);

      // unmapped space reads zero and keeps mapped data intact
      write_byte(16'ha000, 8'hff);
      write_byte(16'hff80, 8'hff);
      write_byte(16'hfe00, 8'hff);
      read_byte(16'ha000);
      read_byte(16'hff80);
      read_byte(16'hfe00);
      read_byte(16'hc000);
      read_byte(16'hde00);
      read_byte(16'hdf80);
      read_byte(16'hc123);
      read_byte(16'h0050);
      read_byte(16'h0150);

      write_byte(gb_bus_pkg::addr_boot, 8'h01);
      read_byte(16'h0050);
      read_byte(gb_bus_pkg::addr_boot);

      // interrupt requests, then a write racing an lcdc request
      pulse_requests(1'b1, 1'b0, 1'b0);
      pulse_requests(1'b0, 1'b1, 1'b0);
      pulse_requests(1'b0, 1'b0, 1'b1);
      read_byte(gb_bus_pkg::addr_if);
      lcdc_req = 1'b1;
      write_byte(gb_bus_pkg::addr_if, 8'he0);
      lcdc_req = 1'b0;
      read_byte(gb_bus_pkg::addr_if);
      write_byte(gb_bus_pkg::addr_ie, 8'hff);
      read_byte(gb_bus_pkg::addr_ie);
      write_byte(gb_bus_pkg::addr_if, 8'h00);

      // timer overflow at the fast period
      write_byte(gb_bus_pkg::addr_tac, 8'h05);
      write_byte(gb_bus_pkg::addr_tma, 8'ha0);
      write_byte(gb_bus_pkg::addr_tima, 8'hfe);
      waited = 0;
      while (!if_flags[gb_bus_pkg::irq_timer] && waited < 64) begin
         @(negedge clock);
         waited++;
      end
      if (!if_flags[gb_bus_pkg::irq_timer]) begin
         other_errors++;
         $display("timer overflow did not raise the timer interrupt within 64 cycles");
      end
      read_byte(gb_bus_pkg::addr_tima);
      read_byte(gb_bus_pkg::addr_tma);
      read_byte(gb_bus_pkg::addr_tac);

      // let DIV climb past 00 before clearing it
      repeat (256) @(negedge clock);
      read_byte(gb_bus_pkg::addr_div);
      write_byte(gb_bus_pkg::addr_div, 8'h77);
      read_byte(gb_bus_pkg::addr_div);
      write_byte(gb_bus_pkg::addr_tac, 8'hf9);
      read_byte(gb_bus_pkg::addr_tac);
      repeat (4) @(negedge clock);

      $display("errors: read data %0d, interrupt flags %0d, other %0d",
               read_errors, flag_errors, other_errors);
      if (read_errors + flag_errors + other_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* design/gb_bus_top.sv */
/*
 * Memory-mapped bus of the console SoC without the CPU core.
 * boot_rom_data and cart_data must answer combinationally to the address outputs.
 * One access per cycle, read data one cycle after cpu_re.
 */

`timescale 1ns/1ps

module gb_bus_top #(
   parameter int WRAM_ADDR_BITS = gb_bus_pkg::wram_addr_bits
) (
   input  logic              clock,
   input  logic              reset,
   input  gb_bus_pkg::addr_t cpu_addr,
   input  gb_bus_pkg::byte_t cpu_wdata,
   input  logic              cpu_we,
   input  logic              cpu_re,
   input  gb_bus_pkg::byte_t boot_rom_data,
   input  gb_bus_pkg::byte_t cart_data,
   input  logic              vblank_req,
   input  logic              lcdc_req,
   input  logic              joypad_req,
   output gb_bus_pkg::byte_t cpu_rdata,
   output gb_bus_pkg::irq_t  if_flags,
   output gb_bus_pkg::irq_t  ie_flags,
   output gb_bus_pkg::addr_t boot_rom_addr,
   output gb_bus_pkg::addr_t cart_addr
);

   gb_bus_pkg::region_t      region;
   logic [WRAM_ADDR_BITS-1:0] wram_index;
   gb_bus_pkg::byte_t        boot_reg;
   gb_bus_pkg::byte_t        wram_rdata;
   gb_bus_pkg::byte_t        timer_rdata;
   logic                     timer_irq;
   gb_bus_pkg::irq_t         irq_set;
   logic                     wram_we;
   logic                     wram_re;
   logic                     timer_we;
   logic                     flags_we;

   assign boot_rom_addr = cpu_addr;
   assign cart_addr     = cpu_addr;

   // per-block strobes
   assign wram_we  = cpu_we && region == gb_bus_pkg::wram;
   assign wram_re  = cpu_re && region == gb_bus_pkg::wram;
   assign timer_we = cpu_we && region == gb_bus_pkg::timer_regs;
   assign flags_we = cpu_we && (region == gb_bus_pkg::if_reg || region == gb_bus_pkg::ie_reg);

   // serial request has no source here
   always_comb begin
      irq_set                        = '0;
      irq_set[0]                     = vblank_req;
      irq_set[1]                     = lcdc_req;
      irq_set[gb_bus_pkg::irq_timer] = timer_irq;
      irq_set[4]                     = joypad_req;
   end

   gb_memory_map #(.WRAM_ADDR_BITS(WRAM_ADDR_BITS)) memory_map_i (
      .clock(clock), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .cpu_we(cpu_we), .region(region), .wram_index(wram_index), .boot_reg(boot_reg)
   );

   gb_work_ram #(.WRAM_ADDR_BITS(WRAM_ADDR_BITS)) work_ram_i (
      .clock(clock), .wram_index(wram_index), .cpu_wdata(cpu_wdata),
      .write_enable(wram_we), .read_enable(wram_re), .wram_rdata(wram_rdata)
   );

   gb_timer timer_i (
      .clock(clock), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .write_enable(timer_we), .timer_rdata(timer_rdata), .timer_irq(timer_irq)
   );

   gb_interrupt_flags interrupt_flags_i (
      .clock(clock), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .write_enable(flags_we), .irq_set(irq_set),
      .if_flags(if_flags), .ie_flags(ie_flags)
   );

   gb_read_mux read_mux_i (
      .clock(clock), .reset(reset), .cpu_re(cpu_re), .region(region),
      .boot_rom_data(boot_rom_data), .cart_data(cart_data), .timer_rdata(timer_rdata),
      .if_flags(if_flags), .ie_flags(ie_flags), .boot_reg(boot_reg),
      .wram_rdata(wram_rdata), .cpu_rdata(cpu_rdata)
   );

endmodule

/* design/gb_read_mux.sv */
/*
 * Registered read data selection with one cycle of latency.
 * For work RAM reads the output follows the RAM's own read register.
 * Read data holds until the next cpu_re.
 */

`timescale 1ns/1ps

module gb_read_mux (
   input  logic                clock,
   input  logic                reset,
   input  logic                cpu_re,
   input  gb_bus_pkg::region_t region,
   input  gb_bus_pkg::byte_t   boot_rom_data,
   input  gb_bus_pkg::byte_t   cart_data,
   input  gb_bus_pkg::byte_t   timer_rdata,
   input  gb_bus_pkg::irq_t    if_flags,
   input  gb_bus_pkg::irq_t    ie_flags,
   input  gb_bus_pkg::byte_t   boot_reg,
   input  gb_bus_pkg::byte_t   wram_rdata,
   output gb_bus_pkg::byte_t   cpu_rdata
);

   gb_bus_pkg::region_t region_q;
   gb_bus_pkg::byte_t   data_q;
   gb_bus_pkg::byte_t   data_sel;

   always_comb begin
      case (region)
         gb_bus_pkg::boot_rom:   data_sel = boot_rom_data;
         gb_bus_pkg::cart:       data_sel = cart_data;
         gb_bus_pkg::timer_regs: data_sel = timer_rdata;
         gb_bus_pkg::if_reg:     data_sel = {3'b000, if_flags};
         gb_bus_pkg::ie_reg:     data_sel = {3'b000, ie_flags};
         gb_bus_pkg::boot_reg:   data_sel = boot_reg;
         default:                data_sel = '0;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         region_q <= gb_bus_pkg::unmapped;
         data_q   <= '0;
      end else if (cpu_re) begin
         region_q <= region;
         // wram data comes from the RAM register instead
         if (region != gb_bus_pkg::wram) begin
            data_q <= data_sel;
         end
      end
   end

   assign cpu_rdata = (region_q == gb_bus_pkg::wram) ? wram_rdata : data_q;

endmodule

/* design/gb_interrupt_flags.sv */
/*
 * Interrupt flag (IF) and interrupt enable (IE) registers.
 * Hardware set requests win over a CPU write of zero to the same bit.
 * Only the low five data bits are stored.
 */

`timescale 1ns/1ps

module gb_interrupt_flags (
   input  logic              clock,
   input  logic              reset,
   input  gb_bus_pkg::addr_t cpu_addr,
   input  gb_bus_pkg::byte_t cpu_wdata,
   input  logic              write_enable,
   input  gb_bus_pkg::irq_t  irq_set,
   output gb_bus_pkg::irq_t  if_flags,
   output gb_bus_pkg::irq_t  ie_flags
);

   logic write_if;
   logic write_ie;

   assign write_if = write_enable && cpu_addr == gb_bus_pkg::addr_if;
   assign write_ie = write_enable && cpu_addr == gb_bus_pkg::addr_ie;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_flags <= '0;
      end else if (write_if) begin
         // requests in the write cycle still land
         if_flags <= cpu_wdata[4:0] | irq_set;
      end else begin
         if_flags <= if_flags | irq_set;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_flags <= '0;
      end else if (write_ie) begin
         ie_flags <= cpu_wdata[4:0];
      end
   end

endmodule

/* design/gb_timer.sv */
/*
 * DIV/TIMA/TMA/TAC timer block.
 * DIV is the upper byte of a free-running 16-bit counter, cleared by any write.
 * A CPU write to TIMA wins over a tick in the same cycle.
 * timer_irq is a one-cycle pulse in the cycle after TIMA overflows.
 */

`timescale 1ns/1ps

module gb_timer (
   input  logic              clock,
   input  logic              reset,
   input  gb_bus_pkg::addr_t cpu_addr,
   input  gb_bus_pkg::byte_t cpu_wdata,
   input  logic              write_enable,
   output gb_bus_pkg::byte_t timer_rdata,
   output logic              timer_irq
);

   logic [15:0]       counter;
   gb_bus_pkg::byte_t tima;
   gb_bus_pkg::byte_t tma;
   logic [2:0]        tac;
   logic [15:0]       period_mask;
   logic              tick;
   logic              write_div;
   logic              write_tima;

   assign write_div  = write_enable && cpu_addr == gb_bus_pkg::addr_div;
   assign write_tima = write_enable && cpu_addr == gb_bus_pkg::addr_tima;

   // tac[1:0] picks the tick period
   always_comb begin
      case (tac[1:0])
         2'd0:    period_mask = 16'h03ff;
         2'd1:    period_mask = 16'h000f;
         2'd2:    period_mask = 16'h003f;
         default: period_mask = 16'h00ff;
      endcase
   end

   // a period completes when the masked low bits are all ones
   assign tick = tac[2] && ((counter & period_mask) == period_mask);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         counter <= '0;
      end else if (write_div) begin
         counter <= '0;
      end else begin
         counter <= counter + 16'd1;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         tima      <= '0;
         tma       <= '0;
         tac       <= '0;
         timer_irq <= 1'b0;
      end else begin
         timer_irq <= 1'b0;
         if (write_tima) begin
            tima <= cpu_wdata;
         end else if (tick) begin
            if (tima == 8'hff) begin
               // overflow reloads from the modulo register
               tima      <= tma;
               timer_irq <= 1'b1;
            end else begin
               tima <= tima + 8'd1;
            end
         end
         if (write_enable && cpu_addr == gb_bus_pkg::addr_tma) begin
            tma <= cpu_wdata;
         end
         if (write_enable && cpu_addr == gb_bus_pkg::addr_tac) begin
            tac <= cpu_wdata[2:0];
         end
      end
   end

   always_comb begin
      case (cpu_addr)
         gb_bus_pkg::addr_div:  timer_rdata = counter[15:8];
         gb_bus_pkg::addr_tima: timer_rdata = tima;
         gb_bus_pkg::addr_tma:  timer_rdata = tma;
         gb_bus_pkg::addr_tac:  timer_rdata = {5'b00000, tac};
         default:               timer_rdata = '0;
      endcase
   end

   // overflows are at least 16 cycles apart
   irq_one_cycle: assert property (@(posedge clock) disable iff (reset)
      timer_irq |=> !timer_irq)
      else $error("timer_irq held high for two cycles");

endmodule

/* design/gb_work_ram.sv */
/*
 * Single-port synchronous work RAM, 2**WRAM_ADDR_BITS bytes.
 * Contents are not cleared by reset.
 * Read data changes only when read_enable is high.
 */

`timescale 1ns/1ps

module gb_work_ram #(
   parameter int WRAM_ADDR_BITS = gb_bus_pkg::wram_addr_bits
) (
   input  logic                      clock,
   input  logic [WRAM_ADDR_BITS-1:0] wram_index,
   input  gb_bus_pkg::byte_t         cpu_wdata,
   input  logic                      write_enable,
   input  logic                      read_enable,
   output gb_bus_pkg::byte_t         wram_rdata
);

   localparam int depth = 2 ** WRAM_ADDR_BITS;

   gb_bus_pkg::byte_t mem [depth];

   always_ff @(posedge clock) begin
      if (write_enable) begin
         mem[wram_index] <= cpu_wdata;
      end
   end

   // output register holds between reads so the mux can keep showing it
   always_ff @(posedge clock) begin
      if (read_enable) begin
         wram_rdata <= mem[wram_index];
      end
   end

   // the bus master never strobes both in one cycle
   single_access: assert property (@(posedge clock)
      !(write_enable && read_enable))
      else $error("work RAM saw a read and a write in the same cycle");

endmodule

/* design/gb_memory_map.sv */
/*
 * Address decoder and boot-ROM overlay register.
 * The overlay covers 0000-00FF until bit 0 of FF50 is written to one.
 * WRAM_ADDR_BITS below 13 makes the work RAM mirror inside C000-FDFF.
 */

`timescale 1ns/1ps

module gb_memory_map #(
   parameter int WRAM_ADDR_BITS = gb_bus_pkg::wram_addr_bits
) (
   input  logic                      clock,
   input  logic                      reset,
   input  gb_bus_pkg::addr_t         cpu_addr,
   input  gb_bus_pkg::byte_t         cpu_wdata,
   input  logic                      cpu_we,
   output gb_bus_pkg::region_t       region,
   output logic [WRAM_ADDR_BITS-1:0] wram_index,
   output gb_bus_pkg::byte_t         boot_reg
);

   logic              in_boot_rom;
   logic              in_cart;
   logic              in_wram;
   logic              in_echo;

   // boot register, bit 0 unmaps the overlay
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         boot_reg <= '0;
      end else if (cpu_we && cpu_addr == gb_bus_pkg::addr_boot) begin
         boot_reg <= cpu_wdata;
      end
   end

   assign in_boot_rom = !boot_reg[0] &&
                        cpu_addr >= gb_bus_pkg::boot_rom_start &&
                        cpu_addr <= gb_bus_pkg::boot_rom_end;
   assign in_cart     = cpu_addr >= gb_bus_pkg::cart_start &&
                        cpu_addr <= gb_bus_pkg::cart_end;
   assign in_wram     = cpu_addr >= gb_bus_pkg::wram_start &&
                        cpu_addr <= gb_bus_pkg::wram_end;
   assign in_echo     = cpu_addr >= gb_bus_pkg::echo_start &&
                        cpu_addr <= gb_bus_pkg::echo_end;

   // one region per access, overlay takes priority over cart
   always_comb begin
      if (in_boot_rom) begin
         region = gb_bus_pkg::boot_rom;
      end else if (in_cart) begin
         region = gb_bus_pkg::cart;
      end else if (in_wram || in_echo) begin
         region = gb_bus_pkg::wram;
      end else if (cpu_addr >= gb_bus_pkg::addr_div && cpu_addr <= gb_bus_pkg::addr_tac) begin
         region = gb_bus_pkg::timer_regs;
      end else if (cpu_addr == gb_bus_pkg::addr_if) begin
         region = gb_bus_pkg::if_reg;
      end else if (cpu_addr == gb_bus_pkg::addr_ie) begin
         region = gb_bus_pkg::ie_reg;
      end else if (cpu_addr == gb_bus_pkg::addr_boot) begin
         region = gb_bus_pkg::boot_reg;
      end else begin
         region = gb_bus_pkg::unmapped;
      end
   end

   // C000 and E000 sit on 8 KiB boundaries, so the offset is the low address bits
   assign wram_index = cpu_addr[WRAM_ADDR_BITS-1:0];

   // every access must land in a defined region once the bus is live
   region_known: assert property (@(posedge clock) disable iff (reset)
      !$isunknown(region))
      else $error("address decoder produced an unknown region");

endmodule

/* design/gb_bus_pkg.sv */
/*
 * Shared bus types, region codes and register addresses for the console bus.
 * Addresses follow the original handheld memory map. Only the regions listed
 * here are decoded, and everything else reads as 00.
 */

package gb_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // bit 0 vblank, 1 lcdc, 2 timer, 3 serial, 4 joypad
   typedef logic [4:0]  irq_t;

   localparam int irq_timer = 2;

   typedef enum logic [2:0] {
      boot_rom,
      cart,
      wram,
      timer_regs,
      if_reg,
      ie_reg,
      boot_reg,
      unmapped
   } region_t;

   // memory-mapped registers
   localparam addr_t addr_div  = 16'hff04;
   localparam addr_t addr_tima = 16'hff05;
   localparam addr_t addr_tma  = 16'hff06;
   localparam addr_t addr_tac  = 16'hff07;
   localparam addr_t addr_if   = 16'hff0f;
   localparam addr_t addr_boot = 16'hff50;
   localparam addr_t addr_ie   = 16'hffff;

   // region bounds, inclusive
   localparam addr_t boot_rom_start = 16'h0000;
   localparam addr_t boot_rom_end   = 16'h00ff;
   localparam addr_t cart_start     = 16'h0000;
   localparam addr_t cart_end       = 16'h7fff;
   localparam addr_t wram_start     = 16'hc000;
   localparam addr_t wram_end       = 16'hdfff;
   localparam addr_t echo_start     = 16'he000;
   localparam addr_t echo_end       = 16'hfdff;

   localparam int wram_addr_bits = 13;

endpackage
